/* hdl/icache_pkg.sv */
package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////

  // meaningful address bits, sets the tag width
  localparam int MEM_ADDR_BITS = 16;
  localparam int CACHE_LINES   = 32;

  // fetch, queue head, next send
  localparam int CACHE_LOOKUPS = 3;

  //////////////////////////////////////////////////////////////////////
  // bus types
  //////////////////////////////////////////////////////////////////////

  typedef logic [63:0] addr_t;

  // zero means no transaction
  typedef logic [3:0] mem_tag_t;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_e;

  // one prefetch queue slot
  typedef struct packed {
    addr_t    address;
    mem_tag_t mem_tag;
    logic     valid;
  } mem_req_t;

  localparam mem_req_t EMPTY_MEM_REQ = '0;

endpackage

/* hdl/cache_mem_if.sv */
`timescale 1ns/1ps

interface cache_mem_if #(
  parameter int NUM_WAYS = 4
);
  import icache_pkg::*;

  localparam int SET_BITS = $clog2(CACHE_LINES / NUM_WAYS);
  localparam int TAG_BITS = MEM_ADDR_BITS - 3 - SET_BITS;

  // lookup 0 fetch, 1 queue head, 2 next block to send
  logic [CACHE_LOOKUPS-1:0]               rd_en;
  logic [CACHE_LOOKUPS-1:0][SET_BITS-1:0] rd_idx;
  logic [CACHE_LOOKUPS-1:0][TAG_BITS-1:0] rd_tag;
  logic [CACHE_LOOKUPS-1:0][63:0]         rd_data;
  logic [CACHE_LOOKUPS-1:0]               rd_hit;

  // fill, applied at the clock edge
  logic                wr_en;
  logic [SET_BITS-1:0] wr_idx;
  logic [TAG_BITS-1:0] wr_tag;
  logic [63:0]         wr_data;

  modport icache (
    output rd_en, rd_idx, rd_tag,
    output wr_en, wr_idx, wr_tag, wr_data,
    input  rd_data, rd_hit
  );

  modport cache_mem (
    input  rd_en, rd_idx, rd_tag,
    input  wr_en, wr_idx, wr_tag, wr_data,
    output rd_data, rd_hit
  );

endinterface

/* hdl/cache_mem.sv */
`timescale 1ns/1ps

module cache_mem #(
  parameter int NUM_WAYS = 4
) (
  input  logic            clock,
  input  logic            reset,
  cache_mem_if.cache_mem  port
);
  import icache_pkg::*;

  localparam int NUM_SETS = CACHE_LINES / NUM_WAYS;
  localparam int SET_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS = MEM_ADDR_BITS - 3 - SET_BITS;
  localparam int WAY_BITS = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
  localparam logic [WAY_BITS-1:0] LAST_WAY = WAY_BITS'(NUM_WAYS - 1);

  logic [NUM_SETS-1:0][NUM_WAYS-1:0] line_valid;
  logic [TAG_BITS-1:0]               line_tag  [NUM_SETS][NUM_WAYS];
  logic [63:0]                       line_data [NUM_SETS][NUM_WAYS];

  // next victim per set
  logic [NUM_SETS-1:0][WAY_BITS-1:0] rr_way;

  logic                fill_match;
  logic [WAY_BITS-1:0] fill_way;

  //////////////////////////////////////////////////////////////////////
  // lookups
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int l = 0; l < CACHE_LOOKUPS; l++) begin
      port.rd_hit[l]  = 1'b0;
      port.rd_data[l] = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (port.rd_en[l] && line_valid[port.rd_idx[l]][w] &&
            line_tag[port.rd_idx[l]][w] == port.rd_tag[l]) begin
          port.rd_hit[l]  = 1'b1;
          port.rd_data[l] = line_data[port.rd_idx[l]][w];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fill and replacement
  //////////////////////////////////////////////////////////////////////

  // reuse the way that already holds this tag
  always_comb begin
    fill_match = 1'b0;
    fill_way   = rr_way[port.wr_idx];
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (line_valid[port.wr_idx][w] && line_tag[port.wr_idx][w] == port.wr_tag) begin
        fill_match = 1'b1;
        fill_way   = WAY_BITS'(w);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
      rr_way     <= '0;
    end else if (port.wr_en) begin
      line_valid[port.wr_idx][fill_way] <= 1'b1;
      if (!fill_match) begin
        if (rr_way[port.wr_idx] == LAST_WAY) begin
          rr_way[port.wr_idx] <= '0;
        end else begin
          rr_way[port.wr_idx] <= rr_way[port.wr_idx] + WAY_BITS'(1);
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (port.wr_en) begin
      line_tag[port.wr_idx][fill_way]  <= port.wr_tag;
      line_data[port.wr_idx][fill_way] <= port.wr_data;
    end
  end

endmodule

/* hdl/prefetch_cam.sv */
`timescale 1ns/1ps

module prefetch_cam #(
  parameter int QUEUE_LEN      = 8,
  parameter int PREFETCH_DEPTH = 2
) (
  input  icache_pkg::addr_t    [PREFETCH_DEPTH:0]  probe_addrs,
  input  icache_pkg::mem_req_t [QUEUE_LEN-1:0]     entries,
  input  logic [$clog2(QUEUE_LEN+1)-1:0]           occupied,
  output logic [PREFETCH_DEPTH:0]                  present
);

  // entry by probe match matrix
  logic [PREFETCH_DEPTH:0][QUEUE_LEN-1:0] match;

  always_comb begin
    for (int p = 0; p <= PREFETCH_DEPTH; p++) begin
      for (int e = 0; e < QUEUE_LEN; e++) begin
        // only slots below the tail count
        match[p][e] = (e < occupied) && entries[e].valid &&
                      (entries[e].address[63:3] == probe_addrs[p][63:3]);
      end
    end
  end

  always_comb begin
    for (int p = 0; p <= PREFETCH_DEPTH; p++) begin
      present[p] = |match[p];
    end
  end

endmodule

/* hdl/icache.sv */
`timescale 1ns/1ps

module icache #(
  parameter int NUM_WAYS       = 4,
  parameter int QUEUE_LEN      = 8,
  parameter int PREFETCH_DEPTH = 2
) (
  input  logic                      clock,
  input  logic                      reset,
  input  icache_pkg::addr_t         fetch_addr,
  output logic [63:0]               fetch_data,
  output logic                      fetch_valid,
  output icache_pkg::bus_command_e  mem_command,
  output icache_pkg::addr_t         mem_addr,
  input  icache_pkg::mem_tag_t      mem_response,
  input  logic [63:0]               mem_data,
  input  icache_pkg::mem_tag_t      mem_tag,
  cache_mem_if.icache               cache
);
  import icache_pkg::*;

  localparam int CW = $clog2(QUEUE_LEN + 1);
  localparam int IW = $clog2(QUEUE_LEN);
  localparam logic [CW-1:0] QUEUE_FULL = CW'(QUEUE_LEN);

  mem_req_t [QUEUE_LEN-1:0] queue, queue_n;
  logic [CW-1:0]            tail, tail_n;
  logic [CW-1:0]            send_ptr, send_ptr_n;
  logic [CW-1:0]            wait_ptr, wait_ptr_n;

  addr_t                    last_fetch_addr;
  addr_t                    fetch_block;
  addr_t [PREFETCH_DEPTH:0] probe_addrs;
  logic [PREFETCH_DEPTH:0]  in_queue;

  logic send_request, send_request_n;
  logic changed_addr;
  logic restart;
  logic head_retire;
  logic send_ready;
  logic accepted;
  logic rejected;
  logic mem_done;

  logic                       fill_en;
  logic [MEM_ADDR_BITS-4:0]   fill_block;
  logic [63:0]                fill_data;

  //////////////////////////////////////////////////////////////////////
  // fetch block and prefetch candidates
  //////////////////////////////////////////////////////////////////////

  assign fetch_block = addr_t'({fetch_addr[MEM_ADDR_BITS-1:3], 3'b000});

  // wraps inside the memory address range
  always_comb begin
    logic [MEM_ADDR_BITS-1:0] probe_low;
    for (int i = 0; i <= PREFETCH_DEPTH; i++) begin
      probe_low      = fetch_block[MEM_ADDR_BITS-1:0] + MEM_ADDR_BITS'(8 * i);
      probe_addrs[i] = addr_t'(probe_low);
    end
  end

  prefetch_cam #(
    .QUEUE_LEN      (QUEUE_LEN),
    .PREFETCH_DEPTH (PREFETCH_DEPTH)
  ) i_prefetch_cam (
    .probe_addrs (probe_addrs),
    .entries     (queue),
    .occupied    (tail),
    .present     (in_queue)
  );

  //////////////////////////////////////////////////////////////////////
  // array lookups and fill
  //////////////////////////////////////////////////////////////////////

  assign send_ready = (send_ptr < tail);

  always_comb begin
    cache.rd_en[0] = 1'b1;
    {cache.rd_tag[0], cache.rd_idx[0]} = fetch_addr[MEM_ADDR_BITS-1:3];
    cache.rd_en[1] = (tail != '0);
    {cache.rd_tag[1], cache.rd_idx[1]} = queue[0].address[MEM_ADDR_BITS-1:3];
    cache.rd_en[2] = send_ready;
    {cache.rd_tag[2], cache.rd_idx[2]} =
      queue[send_ptr[IW-1:0]].address[MEM_ADDR_BITS-1:3];
  end

  assign fetch_data  = cache.rd_data[0];
  assign fetch_valid = cache.rd_hit[0];

  assign cache.wr_en                  = fill_en;
  assign {cache.wr_tag, cache.wr_idx} = fill_block;
  assign cache.wr_data                = fill_data;

  //////////////////////////////////////////////////////////////////////
  // bus side
  //////////////////////////////////////////////////////////////////////

  assign mem_command = send_request ? BUS_LOAD : BUS_NONE;
  assign mem_addr    = send_request ? queue[send_ptr[IW-1:0]].address : '0;

  assign accepted = send_request & (mem_response != '0);
  assign rejected = send_request & (mem_response == '0);

  // tags return in request order
  assign mem_done = (wait_ptr < send_ptr) && (mem_tag != '0) &&
                    (queue[wait_ptr[IW-1:0]].mem_tag == mem_tag);

  //////////////////////////////////////////////////////////////////////
  // queue control
  //////////////////////////////////////////////////////////////////////

  assign changed_addr = (fetch_addr != last_fetch_addr);
  assign restart      = ~cache.rd_hit[0] & ~in_queue[0] & ~send_request;

  // head stays while its own load is on the bus
  assign head_retire = cache.rd_hit[1] & ~(send_request & (send_ptr == '0));

  always_comb begin
    queue_n    = queue;
    tail_n     = tail;
    send_ptr_n = send_ptr;
    wait_ptr_n = wait_ptr;

    if (head_retire) begin
      queue_n = {EMPTY_MEM_REQ, queue[QUEUE_LEN-1:1]};
      tail_n  = tail - CW'(1);
      if (send_ptr != '0) begin
        send_ptr_n = send_ptr - CW'(1);
      end
      if (wait_ptr != '0) begin
        wait_ptr_n = wait_ptr - CW'(1);
      end
    end

    if (mem_done && !(head_retire && wait_ptr == '0)) begin
      wait_ptr_n = wait_ptr_n + CW'(1);
    end

    if (accepted) begin
      queue_n[send_ptr_n[IW-1:0]].mem_tag = mem_response;
      send_ptr_n = send_ptr_n + CW'(1);
    end

    if (restart) begin
      tail_n     = '0;
      send_ptr_n = '0;
      wait_ptr_n = '0;
    end

    // slot 0 of the probes only on a restart
    if (changed_addr || restart) begin
      for (int i = 0; i <= PREFETCH_DEPTH; i++) begin
        if ((restart || (i > 0 && !in_queue[i])) && tail_n < QUEUE_FULL) begin
          queue_n[tail_n[IW-1:0]] = '{address: probe_addrs[i], mem_tag: '0, valid: 1'b1};
          tail_n = tail_n + CW'(1);
        end
      end
    end
  end

  always_comb begin
    if (restart) begin
      send_request_n = 1'b1;
    end else if (send_request) begin
      send_request_n = rejected;
    end else begin
      // already present blocks wait to retire at the head
      send_request_n = send_ready & ~cache.rd_hit[2];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      queue           <= '0;
      tail            <= '0;
      send_ptr        <= '0;
      wait_ptr        <= '0;
      send_request    <= 1'b0;
      last_fetch_addr <= '1;
      fill_en         <= 1'b0;
    end else begin
      queue           <= queue_n;
      tail            <= tail_n;
      send_ptr        <= send_ptr_n;
      wait_ptr        <= wait_ptr_n;
      send_request    <= send_request_n;
      last_fetch_addr <= fetch_addr;
      fill_en         <= mem_done;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_done) begin
      fill_block <= queue[wait_ptr[IW-1:0]].address[MEM_ADDR_BITS-1:3];
      fill_data  <= mem_data;
    end
  end

endmodule

/* hdl/icache_top.sv */
`timescale 1ns/1ps

module icache_top #(
  parameter int NUM_WAYS       = 4,
  parameter int QUEUE_LEN      = 8,
  parameter int PREFETCH_DEPTH = 2
) (
  input  logic                      clock,
  input  logic                      reset,
  input  icache_pkg::addr_t         fetch_addr,
  output logic [63:0]               fetch_data,
  output logic                      fetch_valid,
  output icache_pkg::bus_command_e  mem_command,
  output icache_pkg::addr_t         mem_addr,
  input  icache_pkg::mem_tag_t      mem_response,
  input  logic [63:0]               mem_data,
  input  icache_pkg::mem_tag_t      mem_tag
);

  // controller to array
  cache_mem_if #(.NUM_WAYS(NUM_WAYS)) cache_bus ();

  icache #(
    .NUM_WAYS       (NUM_WAYS),
    .QUEUE_LEN      (QUEUE_LEN),
    .PREFETCH_DEPTH (PREFETCH_DEPTH)
  ) i_icache (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .fetch_data   (fetch_data),
    .fetch_valid  (fetch_valid),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag),
    .cache        (cache_bus.icache)
  );

  cache_mem #(
    .NUM_WAYS (NUM_WAYS)
  ) i_cache_mem (
    .clock (clock),
    .reset (reset),
    .port  (cache_bus.cache_mem)
  );

endmodule

/* test/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clock = ~clock;
    end
  end

endmodule

/* test/mem_model.sv */
`timescale 1ns/1ps

module mem_model #(
  parameter int SEED = 73204
) (
  input  logic                      clock,
  input  logic                      reset,
  input  icache_pkg::bus_command_e  mem_command,
  input  icache_pkg::addr_t         mem_addr,
  output icache_pkg::mem_tag_t      mem_response,
  output logic [63:0]               mem_data,
  output icache_pkg::mem_tag_t      mem_tag
);
  import icache_pkg::*;

  // accepted loads, oldest first
  addr_t    pend_addr[$];
  mem_tag_t pend_tag[$];
  int       pend_due[$];

  function automatic logic [63:0] word_at(addr_t addr);
    return {~addr[31:0], addr[31:0]};
  endfunction

  initial begin
    mem_tag_t next_tag;
    int       cycle;
    int       last_due;
    int       due;

    void'($urandom(SEED));
    mem_response = '0;
    mem_data     = '0;
    mem_tag      = '0;
    next_tag     = 4'h1;
    cycle        = 0;
    last_due     = 0;

    forever begin
      @(posedge clock);
      cycle++;
      if (reset) begin
        pend_addr.delete();
        pend_tag.delete();
        pend_due.delete();
      end else if (mem_command == BUS_LOAD && mem_response != '0) begin
        // answers stay in request order
        due = cycle + 3 + int'($urandom % 8);
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        pend_addr.push_back(mem_addr);
        pend_tag.push_back(mem_response);
        pend_due.push_back(due);
        next_tag = (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
      end

      @(negedge clock);
      mem_response = '0;
      mem_data     = '0;
      mem_tag      = '0;
      if (!reset && pend_due.size() > 0 && pend_due[0] <= cycle) begin
        mem_tag  = pend_tag.pop_front();
        mem_data = word_at(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      // roughly one load in four is turned away
      if (!reset && mem_command == BUS_LOAD && ($urandom % 4) != 0) begin
        mem_response = next_tag;
      end
    end
  end

endmodule

/* test/icache_checker.sv */
`timescale 1ns/1ps

module icache_checker (
  input logic                      clock,
  input logic                      reset,
  input icache_pkg::bus_command_e  mem_command,
  input icache_pkg::addr_t         mem_addr
);
  import icache_pkg::*;

  no_store: assert property (@(posedge clock) disable iff (reset)
    mem_command != BUS_STORE)
  else $error("bus command is a store although the cache only loads");

  // aligned block inside the memory range
  load_addr_legal: assert property (@(posedge clock) disable iff (reset)
    mem_command == BUS_LOAD |->
      (mem_addr[2:0] == 3'b000 && (mem_addr >> MEM_ADDR_BITS) == '0))
  else $error("load address is misaligned or above the memory range");

  idle_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> mem_command == BUS_NONE)
  else $error("bus command is not idle in the cycle after reset");

endmodule

bind icache_top icache_checker i_icache_checker (
  .clock       (clock),
  .reset       (reset),
  .mem_command (mem_command),
  .mem_addr    (mem_addr)
);

/* test/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;
  import icache_pkg::*;

  localparam int CLOCK_PERIOD   = 40;
  localparam int RESET_CYCLES   = 16;
  localparam int PREFETCH_DEPTH = 2;
  localparam int MAX_LINES      = 64;
  localparam int MARGIN_CYCLES  = 200;

  logic         clock;
  logic         reset;
  addr_t        fetch_addr;
  logic [63:0]  fetch_data;
  logic         fetch_valid;
  bus_command_e mem_command;
  addr_t        mem_addr;
  mem_tag_t     mem_response;
  logic [63:0]  mem_data;
  mem_tag_t     mem_tag;

  // address, hold, expect hit per line
  logic [31:0] stim_words [0:3*MAX_LINES-1];
  int          num_lines;
  int          limit_cycles;

  // bus monitor state
  addr_t hold_block;
  addr_t seen_blocks[$];
  logic  last_rejected;
  addr_t last_addr;

  clock_gen #(.PERIOD_NS(CLOCK_PERIOD)) i_clock_gen (.clock(clock));

  icache_top #(
    .NUM_WAYS       (4),
    .QUEUE_LEN      (8),
    .PREFETCH_DEPTH (PREFETCH_DEPTH)
  ) i_icache_top (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .fetch_data   (fetch_data),
    .fetch_valid  (fetch_valid),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag)
  );

  mem_model #(.SEED(73204)) i_mem_model (
    .clock        (clock),
    .reset        (reset),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_tag      (mem_tag)
  );

  ////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////

  // low word is the aligned address, high word its inverse
  function automatic logic [63:0] expected_word(addr_t addr);
    logic [31:0] low;
    low = {addr[31:3], 3'b000};
    return {~low, low};
  endfunction

  task automatic fail_with(string what);
    $display("%s", what);
    $display(">>> FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic flag_mismatch(string name, logic [63:0] got, logic [63:0] want);
    fail_with($sformatf("[ERROR] %s = 0x%h, expected 0x%h", name, got, want));
  endtask

  ////////////////////////////////////////////////////////////////////////
  // stimulus and fetch checks
  ////////////////////////////////////////////////////////////////////////

  initial begin
    addr_t line_addr;
    int    hold;
    logic  expect_hit;
    logic  got_valid;
    int    total_hold;

    reset      = 1'b1;
    fetch_addr = '0;
    hold_block = '0;
    foreach (stim_words[i]) begin
      stim_words[i] = '0;
    end
    $readmemh("test/icache_stimulus.txt", stim_words);

    num_lines  = 0;
    total_hold = 0;
    while (num_lines < MAX_LINES && stim_words[3*num_lines+1] != 0) begin
      total_hold += int'(stim_words[3*num_lines+1]);
      num_lines++;
    end
    assert (num_lines > 0) else fail_with("stimulus file holds no lines");
    limit_cycles = RESET_CYCLES + total_hold + MARGIN_CYCLES;

    repeat (RESET_CYCLES) @(posedge clock);

    for (int n = 0; n < num_lines; n++) begin
      line_addr  = addr_t'(stim_words[3*n]);
      hold       = int'(stim_words[3*n+1]);
      expect_hit = stim_words[3*n+2][0];
      @(negedge clock);
      reset      = 1'b0;
      fetch_addr = line_addr;
      hold_block = {line_addr[63:3], 3'b000};
      seen_blocks.delete();
      got_valid  = 1'b0;
      for (int c = 0; c < hold; c++) begin
        @(posedge clock);
        if (c == 0 && expect_hit) begin
          assert (fetch_valid)
            else flag_mismatch("fetch_valid", 64'(fetch_valid), 64'h1);
        end
        if (fetch_valid) begin
          got_valid = 1'b1;
          assert (fetch_data === expected_word(line_addr))
            else flag_mismatch("fetch_data", fetch_data, expected_word(line_addr));
        end
      end
      assert (got_valid)
        else fail_with($sformatf("fetch_valid never rose for address 0x%h", line_addr));
    end

    $display(">>> PASS");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////
  // bus monitor
  ////////////////////////////////////////////////////////////////////////

  always @(posedge clock) begin
    logic [MEM_ADDR_BITS-1:0] offset;
    if (reset) begin
      last_rejected = 1'b0;
      last_addr     = '0;
    end else begin
      if (last_rejected) begin
        assert (mem_command == BUS_LOAD && mem_addr == last_addr)
          else fail_with($sformatf("rejected load at 0x%h was not repeated", last_addr));
      end
      if (mem_command == BUS_LOAD && mem_response != '0) begin
        // block or one of the next few
        offset = mem_addr[MEM_ADDR_BITS-1:0] - hold_block[MEM_ADDR_BITS-1:0];
        assert (offset <= MEM_ADDR_BITS'(8 * PREFETCH_DEPTH))
          else fail_with($sformatf("[ERROR] mem_addr = 0x%h, expected 0x%h to %0d blocks above",
                                   mem_addr, hold_block, PREFETCH_DEPTH));
        foreach (seen_blocks[i]) begin
          assert (seen_blocks[i] != mem_addr)
            else fail_with($sformatf("block 0x%h loaded twice for one fetch address", mem_addr));
        end
        seen_blocks.push_back(mem_addr);
      end
      last_rejected = (mem_command == BUS_LOAD) && (mem_response == '0);
      last_addr     = mem_addr;
    end
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    #(limit_cycles * CLOCK_PERIOD);
    fail_with($sformatf("watchdog expired after %0d cycles", limit_cycles));
  end

endmodule

/* verilog.f */
hdl/icache_pkg.sv
hdl/cache_mem_if.sv
hdl/cache_mem.sv
hdl/prefetch_cam.sv
hdl/icache.sv
hdl/icache_top.sv
test/clock_gen.sv
test/mem_model.sv
test/icache_checker.sv
test/icache_tb.sv

/* run.sh */
#!/bin/sh
# build and run the icache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module icache_tb \
  -f verilog.f \
  -o icache_sim

./obj_dir/icache_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

/* test/icache_stimulus.txt */
// fetch address, hold cycles, expect hit (1) or new block (0)
// all columns hex, one line per held fetch address
0100 30 0
0108 28 1
0104 28 1
0400 30 0
0118 28 1
0120 28 1
0800 30 0
0c00 30 0
0100 28 1
040c 28 1
1000 30 0
0100 30 0
0800 28 1
1008 28 1
0130 28 1
2000 30 0
2010 28 1
0138 28 1
1004 28 1
0108 28 1
3000 30 0
3008 28 1
